/* verilog/videoDma_consts.svh */
// Sizing macros for the video frame-buffer DMA; include wherever bus or memory widths are needed
`ifndef VIDEODMA_CONSTS_SVH
`define VIDEODMA_CONSTS_SVH

// --------------------------------------------------
// Bus sizing
// --------------------------------------------------
`define UFI_DATA_W 16           // Pixel word and bus data width
`define UFI_ADRS_W 12           // Word address width

// --------------------------------------------------
// Storage sizing
// --------------------------------------------------
`define DMA_FIFO_DEPTH 16       // Upstream write FIFO entries, power of two
`define RAM_WORDS 4096          // Frame RAM size in words

// RAM model back-pressure
// One stall cycle per period
`define RAM_REFRESH_PERIOD 7

`endif

/* verilog/videoDmaPkg.sv */
// Shared types of the frame-buffer DMA: bus opcodes, unit states and UFI request/response
`include "videoDma_consts.svh"

package videoDmaPkg;

	// --------------------------------------------------
	// Bus opcode
	// --------------------------------------------------
	typedef enum logic
	{
		ufiWrite = 1'b0,         // Store wd at adrs
		ufiRead  = 1'b1          // Fetch word, returned next cycle
	} ufiCmdT;

	// DMA unit state
	typedef enum logic [1:0]
	{
		dmaIdle      = 2'd0,     // Disabled, all pointers at buffer 0
		dmaRun       = 2'd1,     // Normal read/write traffic
		dmaWriteHold = 2'd2      // Writer parked at frame boundary
	} dmaStateT;

	// --------------------------------------------------
	// Master to slave request
	// --------------------------------------------------
	typedef struct packed
	{
		logic                   valid;   // Request present, held while not ready
		ufiCmdT                 cmd;
		logic [`UFI_ADRS_W-1:0] adrs;    // Word address
		logic [`UFI_DATA_W-1:0] wd;      // Write data, ignored for reads
	} ufiReqT;

	// Slave to master read return
	typedef struct packed
	{
		logic                   rdValid; // One cycle after read accept
		logic [`UFI_DATA_W-1:0] rd;
	} ufiRspT;

endpackage

/* verilog/dmaWriteFifo.sv */
// Upstream pixel FIFO feeding the DMA writer; pop returns a registered word one cycle later
`timescale 1ns/1ps
`include "videoDma_consts.svh"

module dmaWriteFifo
(
	input  logic                   iClk,
	input  logic                   arstN,
	input  logic [`UFI_DATA_W-1:0] wd,    // Pixel word from upstream
	input  logic                   we,
	input  logic                   re,    // Pop request from DMA unit
	output logic                   full,
	output logic [`UFI_DATA_W-1:0] rd,
	output logic                   rvd,   // Read data valid, one cycle after pop
	output logic                   emp
);

	localparam int IdxW = $clog2(`DMA_FIFO_DEPTH);

	logic [`UFI_DATA_W-1:0] mem [`DMA_FIFO_DEPTH];
	logic [IdxW:0]          wrPtr;   // Extra MSB as wrap flag
	logic [IdxW:0]          rdPtr;
	logic                   doWr;
	logic                   doRd;

	// Same index, different lap -> full
	assign full = (wrPtr[IdxW] != rdPtr[IdxW]) && (wrPtr[IdxW-1:0] == rdPtr[IdxW-1:0]);
	assign emp  = (wrPtr == rdPtr);
	assign doWr = we && !full;
	assign doRd = re && !emp;

	// --------------------------------------------------
	// Pointers and valid pulse
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			rvd   <= 1'b0;
		end
		else
		begin
			if (doWr) wrPtr <= wrPtr + 1'b1;
			if (doRd) rdPtr <= rdPtr + 1'b1;
			rvd <= doRd;                      // Pulse aligned with rd
		end
	end

	// Storage and output word
	always_ff @(posedge iClk)
	begin
		if (doWr) mem[wrPtr[IdxW-1:0]] <= wd;
		if (doRd) rd <= mem[rdPtr[IdxW-1:0]];
	end

	// Neither side may overrun its flag
	aNoOverUnder : assert property (@(posedge iClk) disable iff (!arstN)
		!(we && full) && !(re && emp))
		else $error("dmaWriteFifo: write while full or read while empty");

endmodule

/* verilog/videoDmaUnit.sv */
// Double-buffer frame DMA: arbitrates FIFO writes and downstream reads onto the UFI bus
`timescale 1ns/1ps
`include "videoDma_consts.svh"

module videoDmaUnit
	import videoDmaPkg::*;
(
	input  logic                   iClk,
	input  logic                   arstN,
	input  logic                   iDmaEn,
	input  logic                   iDmaRe,       // Downstream has room for two words
	input  logic [`UFI_ADRS_W-1:0] iBufAdrs0,    // Buffer 0 base
	input  logic [`UFI_ADRS_W-1:0] iBufAdrs1,    // Buffer 1 base
	input  logic [`UFI_ADRS_W-1:0] iFrameLen,    // Words per frame
	input  logic [`UFI_DATA_W-1:0] fifoRd,
	input  logic                   fifoRvd,
	input  logic                   fifoEmp,
	input  logic                   ufiRdy,
	input  ufiRspT                 ufiRsp,
	output logic                   fifoRe,
	output ufiReqT                 ufiReq,
	output logic [`UFI_DATA_W-1:0] oDmaRd,
	output logic                   oDmaREd
);

	dmaStateT               state;
	ufiReqT                 reqQ;        // Request register driving the bus
	ufiReqT                 reqNext;
	logic                   wrSel;       // Buffer being written
	logic                   rdSel;       // Buffer being read
	logic                   doneSel;     // Last completed buffer
	logic [`UFI_ADRS_W-1:0] wrOfs;
	logic [`UFI_ADRS_W-1:0] rdOfs;
	logic [`UFI_ADRS_W-1:0] frameLast;
	logic                   wSel;
	logic                   rSel;
	logic                   stall;
	logic                   wrLoad;
	logic                   rdLoad;
	logic                   holdNeeded;

	assign ufiReq    = reqQ;
	assign frameLast = iFrameLen - 1'b1;
	assign stall     = reqQ.valid && !ufiRdy;   // Request must sit unchanged

	// --------------------------------------------------
	// Buffer choice at frame start
	// --------------------------------------------------
	// Writer always targets the buffer opposite the last completed one
	assign wSel = (wrOfs == '0) ? ~doneSel : wrSel;
	assign rSel = (rdOfs == '0) ? doneSel : rdSel;   // Reader latches newest frame

	// Reader still inside the buffer the writer wants next
	assign holdNeeded = (rdOfs != '0) && (rdSel == ~doneSel);

	// Load events, updated at issue since an issued request is never dropped
	assign wrLoad = iDmaEn && !stall && fifoRvd;
	assign rdLoad = iDmaEn && !stall && !fifoRvd && iDmaRe;

	// Pop only with a free bus slot next cycle and no read wanted
	assign fifoRe = iDmaEn && (state == dmaRun) && !iDmaRe && !fifoEmp && !fifoRvd && !stall;

	// --------------------------------------------------
	// Next bus request
	// --------------------------------------------------
	always_comb
	begin
		reqNext.valid = 1'b0;
		reqNext.cmd   = ufiRead;
		reqNext.adrs  = (rSel ? iBufAdrs1 : iBufAdrs0) + rdOfs;
		reqNext.wd    = fifoRd;
		if (fifoRvd)                            // Popped word goes out first
		begin
			reqNext.valid = 1'b1;
			reqNext.cmd   = ufiWrite;
			reqNext.adrs  = (wSel ? iBufAdrs1 : iBufAdrs0) + wrOfs;
		end
		else if (iDmaRe)
			reqNext.valid = 1'b1;
	end

	// --------------------------------------------------
	// State, offsets and request register
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= dmaIdle;
			reqQ    <= '0;
			wrSel   <= 1'b0;
			rdSel   <= 1'b0;
			doneSel <= 1'b0;
			wrOfs   <= '0;
			rdOfs   <= '0;
			oDmaREd <= 1'b0;
		end
		else if (!iDmaEn)
		begin
			state   <= dmaIdle;                 // Back to buffer 0 base
			reqQ.valid <= 1'b0;
			wrSel   <= 1'b0;
			rdSel   <= 1'b0;
			doneSel <= 1'b0;
			wrOfs   <= '0;
			rdOfs   <= '0;
			oDmaREd <= 1'b0;
		end
		else
		begin
			if (state == dmaIdle) state <= dmaRun;
			if (state == dmaWriteHold && !holdNeeded) state <= dmaRun;   // Reader left
			if (!stall) reqQ <= reqNext;
			if (wrLoad)
			begin
				wrSel <= wSel;
				if (wrOfs == frameLast)          // Frame complete
				begin
					wrOfs   <= '0;
					doneSel <= wSel;
					if ((rdOfs != '0) && (rdSel == ~wSel)) state <= dmaWriteHold;
				end
				else
					wrOfs <= wrOfs + 1'b1;
			end
			if (rdLoad)
			begin
				rdSel <= rSel;
				rdOfs <= (rdOfs == frameLast) ? '0 : rdOfs + 1'b1;
			end
			oDmaREd <= ufiRsp.rdValid;          // Two cycles after accept
		end
	end

	// Downstream data, follows the RAM return
	always_ff @(posedge iClk)
	begin
		oDmaRd <= ufiRsp.rd;
	end

	// Writer and reader never share a buffer mid-frame
	aBufApart : assert property (@(posedge iClk) disable iff (!arstN)
		(wrOfs != '0) && (rdOfs != '0) |-> (wrSel != rdSel))
		else $error("videoDmaUnit: writer and reader in same buffer");

endmodule

/* verilog/ufiRam.sv */
// UFI slave RAM model: one-cycle read latency and a periodic one-cycle refresh stall
`timescale 1ns/1ps
`include "videoDma_consts.svh"

module ufiRam
	import videoDmaPkg::*;
(
	input  logic   iClk,
	input  logic   arstN,
	input  ufiReqT ufiReq,
	output logic   ufiRdy,    // Low one cycle per refresh period
	output ufiRspT ufiRsp
);

	localparam int CntW = $clog2(`RAM_REFRESH_PERIOD);
	localparam logic [CntW-1:0] RefLast = CntW'(`RAM_REFRESH_PERIOD - 1);

	logic [`UFI_DATA_W-1:0] mem [`RAM_WORDS];
	logic [CntW-1:0]        refCnt;
	logic                   accept;

	assign ufiRdy = (refCnt != RefLast);     // Refresh slot
	assign accept = ufiReq.valid && ufiRdy;

	// --------------------------------------------------
	// Refresh counter, storage, read return
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			refCnt <= '0;
			ufiRsp <= '0;
			for (int i = 0; i < `RAM_WORDS; i++)
				mem[i] <= '0;                     // Frames read as black
		end
		else
		begin
			refCnt <= (refCnt == RefLast) ? '0 : refCnt + 1'b1;
			if (accept && ufiReq.cmd == ufiWrite) mem[ufiReq.adrs] <= ufiReq.wd;
			ufiRsp.rdValid <= accept && (ufiReq.cmd == ufiRead);
			ufiRsp.rd      <= mem[ufiReq.adrs];
		end
	end

	// Stalled request held, or withdrawn when the master is disabled
	aHoldStalled : assert property (@(posedge iClk) disable iff (!arstN)
		ufiReq.valid && !ufiRdy |=> $stable(ufiReq) || !ufiReq.valid)
		else $error("ufiRam: stalled request changed before accept");

endmodule

/* verilog/videoDmaTop.sv */
// Frame-buffer DMA subsystem top: write FIFO, DMA unit and UFI RAM model wired together
`timescale 1ns/1ps
`include "videoDma_consts.svh"

module videoDmaTop
	import videoDmaPkg::*;
(
	input  logic                   iClk,
	input  logic                   arstN,
	input  logic                   iDmaEn,
	input  logic [`UFI_DATA_W-1:0] iDmaWd,      // Upstream pixel word
	input  logic                   iDmaWEd,
	input  logic                   iDmaRe,      // Downstream read request level
	input  logic [`UFI_ADRS_W-1:0] iBufAdrs0,
	input  logic [`UFI_ADRS_W-1:0] iBufAdrs1,
	input  logic [`UFI_ADRS_W-1:0] iFrameLen,
	output logic                   oDmaFull,
	output logic [`UFI_DATA_W-1:0] oDmaRd,
	output logic                   oDmaREd
);

	// --------------------------------------------------
	// FIFO to unit, unit to RAM
	// --------------------------------------------------
	logic [`UFI_DATA_W-1:0] fifoRd;
	logic                   fifoRvd;
	logic                   fifoEmp;
	logic                   fifoRe;
	ufiReqT                 ufiReq;
	ufiRspT                 ufiRsp;
	logic                   ufiRdy;

	dmaWriteFifo uFifo (.iClk(iClk), .arstN(arstN), .wd(iDmaWd), .we(iDmaWEd), .re(fifoRe),
		.full(oDmaFull), .rd(fifoRd), .rvd(fifoRvd), .emp(fifoEmp));

	videoDmaUnit uUnit (.iClk(iClk), .arstN(arstN), .iDmaEn(iDmaEn), .iDmaRe(iDmaRe),
		.iBufAdrs0(iBufAdrs0), .iBufAdrs1(iBufAdrs1), .iFrameLen(iFrameLen),
		.fifoRd(fifoRd), .fifoRvd(fifoRvd), .fifoEmp(fifoEmp), .ufiRdy(ufiRdy),
		.ufiRsp(ufiRsp), .fifoRe(fifoRe), .ufiReq(ufiReq), .oDmaRd(oDmaRd),
		.oDmaREd(oDmaREd));

	ufiRam uRam (.iClk(iClk), .arstN(arstN), .ufiReq(ufiReq), .ufiRdy(ufiRdy),
		.ufiRsp(ufiRsp));

endmodule

/* testbench/videoDmaTb.sv */
// Testbench for the frame-buffer DMA top; drives pixel frames and random reads, assertions check
`timescale 1ns/1ps
`include "videoDma_consts.svh"

module videoDmaTb;

	localparam int FrameLen = 32;
	localparam int Frames1  = 10;                    // First enable session
	localparam int Frames2  = 8;                     // After re-enable
	localparam int TimeoutCycles = 40 * 32 * 4 + 500;
	localparam int TagW = `UFI_DATA_W - 6;

	logic                   iClk;
	logic                   arstN;
	logic                   iDmaEn;
	logic [`UFI_DATA_W-1:0] iDmaWd;
	logic                   iDmaWEd;
	logic                   iDmaRe;
	logic [`UFI_ADRS_W-1:0] iBufAdrs0;
	logic [`UFI_ADRS_W-1:0] iBufAdrs1;
	logic [`UFI_ADRS_W-1:0] iFrameLen;
	logic                   oDmaFull;
	logic [`UFI_DATA_W-1:0] oDmaRd;
	logic                   oDmaREd;

	int unsigned errCnt = 0;
	int unsigned cycles = 0;
	int unsigned rdMode = 1;                         // 0 random, 1 off, 2 always on
	int unsigned session = 1;
	int unsigned fifoOcc;                            // Words held by the write FIFO
	logic [TagW-1:0] baseTag;                        // Old frame left in buffer 0
	logic [4:0]      pos;                            // Word position in read frame
	logic [TagW-1:0] tag;
	logic [TagW-1:0] lastReadTag;
	logic            blank;                          // Current read frame is all zero
	logic            seenReal;
	int unsigned     readFrames;
	logic [TagW-1:0] srcDoneTag;                     // Last frame fully pushed upstream
	logic            srcDoneV;
	logic [2:0]      empCnt;
	logic [3:0]      cmtV;                           // Commit pipeline, oldest at [3]
	logic [TagW-1:0] cmtTag [4];
	logic [TagW-1:0] dTag;
	logic [5:0]      dLow;
	logic            wordOk;
	logic            tagOk;

	videoDmaTop u_dut (.iClk(iClk), .arstN(arstN), .iDmaEn(iDmaEn), .iDmaWd(iDmaWd),
		.iDmaWEd(iDmaWEd), .iDmaRe(iDmaRe), .iBufAdrs0(iBufAdrs0), .iBufAdrs1(iBufAdrs1),
		.iFrameLen(iFrameLen), .oDmaFull(oDmaFull), .oDmaRd(oDmaRd), .oDmaREd(oDmaREd));

	initial
	begin
		iClk = 1'b0;
		forever #5 iClk = ~iClk;
	end

	// --------------------------------------------------
	// Expected word and tag rules
	// --------------------------------------------------
	assign dTag = oDmaRd[`UFI_DATA_W-1:6];
	assign dLow = oDmaRd[5:0];

	always_comb
	begin
		if (pos == 0)
			wordOk = (dLow == 0);
		else if (pos == 1)                          // Blank vs frame decided here
			wordOk = (oDmaRd == 0) ? (session == 1 && !seenReal && tag == 0)
				: (dTag == tag && dLow == 1);
		else
			wordOk = blank ? (oDmaRd == 0) : (dTag == tag && dLow == 6'(pos));
		tagOk = (dTag >= tag) && (!cmtV[3] || dTag >= cmtTag[3])
			&& (session == 1 || dTag >= TagW'(Frames1) || dTag == baseTag);
	end

	// Read frame tracking and commit estimate
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN || !iDmaEn)
		begin
			pos <= '0;
			tag <= '0;
			blank <= 1'b0;
			srcDoneV <= 1'b0;
			empCnt <= '0;
			cmtV <= '0;
			if (!arstN)
			begin
				seenReal <= 1'b0;
				readFrames <= 0;
				lastReadTag <= '0;
				srcDoneTag <= '0;
			end
		end
		else
		begin
			if (iDmaWEd && iDmaWd[5:0] == 6'd31)
			begin
				srcDoneTag <= iDmaWd[`UFI_DATA_W-1:6];
				srcDoneV   <= 1'b1;
			end
			empCnt <= !u_dut.fifoEmp ? 3'd0 : (empCnt == 3'd7 ? empCnt : empCnt + 1'b1);
			cmtV <= {cmtV[2:0], (empCnt == 3'd3 && srcDoneV) || cmtV[0]};
			cmtTag[0] <= (empCnt == 3'd3 && srcDoneV) ? srcDoneTag : cmtTag[0];
			for (int i = 1; i < 4; i++)
				cmtTag[i] <= cmtTag[i-1];
			if (oDmaREd)
			begin
				pos <= pos + 1'b1;                     // Wraps at 32
				if (pos == 0)
					tag <= dTag;
				if (pos == 1)
				begin
					blank <= (oDmaRd == 0);
					if (oDmaRd != 0) seenReal <= 1'b1;
				end
				if (pos == 5'd31)
				begin
					readFrames <= readFrames + 1;
					lastReadTag <= tag;
				end
			end
		end
	end

	// Write FIFO occupancy from pushes and pops
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			fifoOcc <= 0;
		else
			fifoOcc <= fifoOcc + ((iDmaWEd && fifoOcc != `DMA_FIFO_DEPTH) ? 1 : 0)
				- ((u_dut.fifoRe && fifoOcc != 0) ? 1 : 0);
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	aWord : assert property (@(posedge iClk) disable iff (!arstN) oDmaREd |-> wordOk)
		else
		begin
			errCnt++;
			$display("[FAIL] %0t read word %h wrong at pos %0d", $time, oDmaRd, pos);
		end
	aTag : assert property (@(posedge iClk) disable iff (!arstN) oDmaREd && pos == 0 |-> tagOk)
		else
		begin
			errCnt++;
			$display("[FAIL] %0t read frame tag %0d out of order", $time, dTag);
		end
	aFull : assert property (@(posedge iClk) disable iff (!arstN)
		oDmaFull == (fifoOcc == `DMA_FIFO_DEPTH))
		else
		begin
			errCnt++;
			$display("[FAIL] %0t full flag %0b with %0d words held", $time, oDmaFull, fifoOcc);
		end
	aQuiet : assert property (@(posedge iClk) disable iff (!arstN)
		!iDmaEn ##1 !iDmaEn |-> !oDmaREd)
		else
		begin
			errCnt++;
			$display("[FAIL] %0t read strobe while disabled", $time);
		end

	// Downstream reader, inputs move 1 ns after the edge
	always @(posedge iClk)
	begin
		#1;
		iDmaRe <= (rdMode == 2) || (rdMode == 0 && ($urandom % 3 == 0));
	end

	// Pushes whole frames, word k of frame f is f*64+k
	task automatic sendFrames(input int firstTag, input int count);
		int k;
		for (int f = firstTag; f < firstTag + count; f++)
		begin
			k = 0;
			while (k < FrameLen)
			begin
				@(posedge iClk);
				#1;
				iDmaWEd = 1'b0;
				if (!oDmaFull && ($urandom % 4 != 0))
				begin
					iDmaWd  = `UFI_DATA_W'(f * 64 + k);
					iDmaWEd = 1'b1;
					k++;
				end
			end
		end
		@(posedge iClk);
		#1 iDmaWEd = 1'b0;
	endtask

	// Waits for the FIFO to empty, then reads two frames and expects the newest tag
	task automatic drainAndCheck();
		int quiet;
		int startCnt;
		quiet = 0;
		while (quiet < 6)
		begin
			@(posedge iClk);
			quiet = u_dut.fifoEmp ? quiet + 1 : 0;
		end
		rdMode = 2;
		startCnt = readFrames;
		while (readFrames < startCnt + 2)
			@(posedge iClk);
		aNewest : assert (lastReadTag == srcDoneTag)
			else
			begin
				errCnt++;
				$display("[FAIL] %0t frame %0d never read back", $time, srcDoneTag);
			end
		rdMode = 1;
		repeat (5) @(posedge iClk);                  // Let in-flight reads land
	endtask

	initial
	begin
		void'($urandom(89));
		arstN = 1'b0;
		iDmaEn = 1'b0;
		iDmaWd = '0;
		iDmaWEd = 1'b0;
		iDmaRe = 1'b0;
		iBufAdrs0 = 0;
		iBufAdrs1 = 256;
		iFrameLen = FrameLen;
		baseTag = ((Frames1 - 1) % 2 == 1) ? TagW'(Frames1 - 1) : TagW'(Frames1 - 2);
		repeat (3) @(posedge iClk);
		#1 arstN = 1'b1;
		iDmaEn = 1'b1;
		rdMode = 0;
		sendFrames(0, Frames1);
		drainAndCheck();
		// Disabled stretch with reads toggling
		#1 iDmaEn = 1'b0;
		session = 2;
		rdMode = 0;
		repeat (20) @(posedge iClk);
		#1 iDmaEn = 1'b1;
		sendFrames(Frames1, Frames2);
		drainAndCheck();
		$display("Errors: %0d", errCnt);
		if (errCnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Run limit
	always @(posedge iClk)
	begin
		cycles++;
		if (cycles == TimeoutCycles)
		begin
			$display("The run timed out after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+verilog
verilog/videoDmaPkg.sv
verilog/dmaWriteFifo.sv
verilog/videoDmaUnit.sv
verilog/ufiRam.sv
verilog/videoDmaTop.sv
testbench/videoDmaTb.sv

/* Makefile */
# Verilator build and run of the frame-buffer DMA testbench

TB  = videoDmaTb
BIN = obj_dir/V$(TB)

.PHONY: all run lint clean

all: run

$(BIN): verilog.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f verilog.f --top-module $(TB)

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TB)

clean:
	rm -rf obj_dir sim.log
